// ==== sysCtrl.f ====
common/sysCtrlPkg.sv
rtl/cmdDecoder.sv
rtl/respSender.sv
rtl/sysCtrl.sv
verification/sysCtrlTb.sv

// ==== Makefile ====
BIN = obj_dir/VsysCtrlTb

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

$(BIN): sysCtrl.f $(shell cat sysCtrl.f)
	verilator --binary --timing --assert -Wno-fatal --top-module sysCtrlTb -f sysCtrl.f

clean:
	rm -rf obj_dir

// ==== verification/sysCtrlTb.sv ====
`timescale 1ns/1ps

module sysCtrlTb
    import sysCtrlPkg::*;
();

    localparam logic [AddrWidth-1:0] OpAAddr  = 4'd3;   // Off the defaults to exercise the params
    localparam logic [AddrWidth-1:0] OpBAddr  = 4'd9;
    localparam int                   NumTests = 5;

    logic                   REF_CLK;
    logic                   RST;
    logic [DataWidth-1:0]   rxData;
    logic                   rxValid;
    logic [DataWidth-1:0]   rfRdData;
    logic                   rfRdValid;
    logic [AluOutWidth-1:0] aluOut;
    logic                   aluOutValid;
    logic                   txBusy;
    rfReqT                  rfReq;
    aluReqT                 aluReq;
    logic [DataWidth-1:0]   txData;
    logic                   txValid;

    logic [DataWidth-1:0]   mem [16];                   // Register file model contents
    logic [DataWidth-1:0]   txQ [$];                    // Bytes taken by the UART model
    integer                 seed     = 86;
    int                     errors   = 0;
    logic                   longBusy = 1'b0;            // Stretch txBusy for back-pressure

    sysCtrl #(.OperandAAddr(OpAAddr), .OperandBAddr(OpBAddr)) sysCtrl_i (.*);

    initial
    begin
        REF_CLK = 1'b0;
        forever #5 REF_CLK = ~REF_CLK;
    end

    // Register file model, writes sampled mid-cycle
    initial
    begin
        for (int i = 0; i < 16; i++)
        begin
            mem[i] = 8'(i * 29 + 7);                    // Distinct value per address
        end
        forever
        begin
            @(negedge REF_CLK);
            if (rfReq.wrEn)
            begin
                mem[rfReq.addr] = rfReq.wrData;
            end
        end
    end

    initial
    begin : rfReadModel
        logic [AddrWidth-1:0] addr;
        int                   lat;
        forever
        begin
            @(negedge REF_CLK);
            if (rfReq.rdEn)
            begin
                addr = rfReq.addr;
                lat  = 1 + {$random(seed)} % 4;         // 1 to 4 cycles
                repeat (lat) @(posedge REF_CLK);
                #1;
                rfRdData  = mem[addr];
                rfRdValid = 1'b1;
                @(posedge REF_CLK);
                #1;
                rfRdValid = 1'b0;
            end
        end
    end

    // ALU model, 0 add, 1 subtract, otherwise multiply
    initial
    begin : aluModel
        logic [AluFunWidth-1:0] fun;
        logic [AluOutWidth-1:0] a;
        logic [AluOutWidth-1:0] b;
        int                     lat;
        forever
        begin
            @(negedge REF_CLK);
            if (aluReq.en)
            begin
                fun = aluReq.fun;
                a   = {8'h00, mem[OpAAddr]};
                b   = {8'h00, mem[OpBAddr]};
                lat = 1 + {$random(seed)} % 5;
                repeat (lat - 1)
                begin
                    @(negedge REF_CLK);
                    checkAlu(aluReq, '{en: 1'b1, clkEn: 1'b1, fun: fun}, "aluReq"); // Held in wait
                end
                @(posedge REF_CLK);
                #1;
                case (fun)
                    4'd0:    aluOut = a + b;
                    4'd1:    aluOut = a - b;
                    default: aluOut = a * b;
                endcase
                aluOutValid = 1'b1;
                @(posedge REF_CLK);
                #1;
                aluOutValid = 1'b0;
            end
        end
    end

    // UART transmitter model, busy for a while after each byte
    initial
    begin : uartTxModel
        int hold;
        forever
        begin
            @(negedge REF_CLK);
            if (txValid)
            begin
                txQ.push_back(txData);
                hold = longBusy ? 15 + {$random(seed)} % 6 : 2 + {$random(seed)} % 5;
                @(posedge REF_CLK);
                #1;
                txBusy = 1'b1;
                repeat (hold) @(posedge REF_CLK);
                #1;
                txBusy = 1'b0;
            end
        end
    end

    initial
    begin
        #(200 * NumTests * 10);                         // 200 cycles per test
        $display("watchdog expired before the tests finished at %0t", $time);
        errors++;
        endRun();
    end

    task automatic checkRf(input rfReqT act, input rfReqT exp, input string name);
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %0t %s: got %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic checkAlu(input aluReqT act, input aluReqT exp, input string name);
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %0t %s: got %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic checkByte(input logic [DataWidth-1:0] act, input logic [DataWidth-1:0] exp,
                             input string name);
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %0t %s: got %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic checkCount(input int act, input int exp, input string name);
        if (act != exp)
        begin
            errors++;
            $display("FAIL %0t %s: got %0d expected %0d", $time, name, act, exp);
        end
    endtask

    // All stimulus tasks start and end 1 ns after a rising edge
    task automatic sendByte(input logic [DataWidth-1:0] b);
        rxData  = b;
        rxValid = 1'b1;
        @(posedge REF_CLK);
        #1;
        rxValid = 1'b0;
    endtask

    task automatic sendCheckRf(input logic [DataWidth-1:0] b, input rfReqT exp);
        rxData  = b;
        rxValid = 1'b1;
        #3;                                             // Request is combinational
        checkRf(rfReq, exp, "rfReq");
        @(posedge REF_CLK);
        #1;
        rxValid = 1'b0;
    endtask

    task automatic sendCheckAlu(input logic [DataWidth-1:0] b, input aluReqT exp);
        rxData  = b;
        rxValid = 1'b1;
        #3;
        checkAlu(aluReq, exp, "aluReq");
        @(posedge REF_CLK);
        #1;
        rxValid = 1'b0;
    endtask

    task automatic waitBytes(input int n);
        int cycles;
        cycles = 0;
        while (txQ.size() < n && cycles < 150)
        begin
            @(posedge REF_CLK);
            #1;
            cycles++;
        end
        if (txQ.size() < n)
        begin
            errors++;
            $display("response bytes did not arrive within 150 cycles at %0t", $time);
        end
        repeat (25) @(posedge REF_CLK);                 // Room for a stray extra byte
        #1;
        checkCount(txQ.size(), n, "txByteCount");
    endtask

    task automatic expectByte(input logic [DataWidth-1:0] exp);
        if (txQ.size() == 0)
        begin
            errors++;
            $display("expected byte %h was never transmitted", exp);
        end
        else
        begin
            checkByte(txQ.pop_front(), exp, "txData");
        end
    endtask

    task automatic writeReg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
        sendByte(RfWrite);
        sendCheckRf({4'h0, addr}, '0);                  // Address byte, no request yet
        sendCheckRf(data, '{wrEn: 1'b1, rdEn: 1'b0, addr: addr, wrData: data});
    endtask

    task automatic readReg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] exp);
        sendByte(RfRead);
        sendByte({4'h0, addr});
        waitBytes(1);
        expectByte(exp);
    endtask

    task automatic testReset();
        checkRf(rfReq, '0, "rfReq");
        checkAlu(aluReq, '0, "aluReq");
        checkCount(int'(txValid), 0, "txValid");
        sendCheckRf(8'h55, '0);                         // Not an opcode
        waitBytes(0);
        checkAlu(aluReq, '0, "aluReq");
    endtask

    task automatic testWriteRead();
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] data;
        addr = AddrWidth'($random(seed));
        data = DataWidth'($random(seed));
        writeReg(addr, data);
        readReg(addr, data);
    endtask

    task automatic testAluOperands();
        logic [DataWidth-1:0]   a;
        logic [DataWidth-1:0]   b;
        logic [AluOutWidth-1:0] sum;
        a   = 8'h7F & DataWidth'($random(seed));        // Sum stays below 256
        b   = 8'h7F & DataWidth'($random(seed));
        sum = {8'h00, a} + {8'h00, b};
        sendByte(AluWithOp);
        sendCheckRf(a, '{wrEn: 1'b1, rdEn: 1'b0, addr: OpAAddr, wrData: a});
        sendCheckRf(b, '{wrEn: 1'b1, rdEn: 1'b0, addr: OpBAddr, wrData: b});
        sendCheckAlu(8'h00, '{en: 1'b1, clkEn: 1'b1, fun: 4'h0});
        waitBytes(1);
        expectByte(sum[7:0]);
    endtask

    task automatic testAluWide();
        logic [DataWidth-1:0]   a;
        logic [DataWidth-1:0]   b;
        logic [AluOutWidth-1:0] prod;
        a    = 8'h80 | DataWidth'($random(seed));       // Product high byte nonzero
        b    = 8'h80 | DataWidth'($random(seed));
        prod = {8'h00, a} * {8'h00, b};
        writeReg(OpAAddr, a);
        writeReg(OpBAddr, b);
        sendByte(AluNoOp);
        sendCheckAlu(8'h02, '{en: 1'b1, clkEn: 1'b1, fun: 4'h2});
        waitBytes(2);
        expectByte(prod[7:0]);
        expectByte(prod[15:8]);
    endtask

    task automatic testBackPressure();
        logic [DataWidth-1:0]   a;
        logic [DataWidth-1:0]   b;
        logic [AluOutWidth-1:0] prod;
        logic [AluOutWidth-1:0] diff;
        a    = 8'h10 | (8'h2F & DataWidth'($random(seed)));
        b    = 8'hC0 | DataWidth'($random(seed));       // a below b, difference wraps
        prod = {8'h00, a} * {8'h00, b};
        diff = {8'h00, a} - {8'h00, b};
        longBusy = 1'b1;
        writeReg(OpAAddr, a);
        writeReg(OpBAddr, b);
        sendByte(AluNoOp);
        sendByte(8'h02);
        waitBytes(2);
        expectByte(prod[7:0]);
        expectByte(prod[15:8]);
        sendByte(AluNoOp);
        sendByte(8'h01);
        waitBytes(2);
        expectByte(diff[7:0]);
        expectByte(diff[15:8]);
        longBusy = 1'b0;
        readReg(OpBAddr, b);                            // Decoder still in step
    endtask

    task automatic endRun();
        $display("errors: %0d", errors);
        if (errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial
    begin
        RST         = 1'b0;
        rxData      = '0;
        rxValid     = 1'b0;
        rfRdData    = '0;
        rfRdValid   = 1'b0;
        aluOut      = '0;
        aluOutValid = 1'b0;
        txBusy      = 1'b0;
        repeat (10) @(posedge REF_CLK);
        #1;
        RST = 1'b1;
        testReset();
        testWriteRead();
        testAluOperands();
        testAluWide();
        testBackPressure();
        endRun();
    end

endmodule

// ==== rtl/sysCtrl.sv ====
`timescale 1ns/1ps

module sysCtrl
    import sysCtrlPkg::*;
#(
    parameter logic [AddrWidth-1:0] OperandAAddr = 0,   // ALU operand A register
    parameter logic [AddrWidth-1:0] OperandBAddr = 1    // ALU operand B register
)
(
    input  logic                   REF_CLK,
    input  logic                   RST,
    input  logic [DataWidth-1:0]   rxData,              // UART receiver byte
    input  logic                   rxValid,
    input  logic [DataWidth-1:0]   rfRdData,            // Register file read port
    input  logic                   rfRdValid,
    input  logic [AluOutWidth-1:0] aluOut,              // ALU result port
    input  logic                   aluOutValid,
    input  logic                   txBusy,              // UART transmitter status
    output rfReqT                  rfReq,
    output aluReqT                 aluReq,
    output logic [DataWidth-1:0]   txData,
    output logic                   txValid
);

    respReqT respReq;                                   // Result handed to the sender
    logic    respDone;                                  // Sender finished, decoder may resume

    // Command FSM, drives register file and ALU
    cmdDecoder #(
        .OperandAAddr (OperandAAddr),
        .OperandBAddr (OperandBAddr)
    ) cmdDecoder_i (
        .REF_CLK     (REF_CLK),
        .RST         (RST),
        .rxData      (rxData),
        .rxValid     (rxValid),
        .rfRdData    (rfRdData),
        .rfRdValid   (rfRdValid),
        .aluOut      (aluOut),
        .aluOutValid (aluOutValid),
        .respDone    (respDone),
        .rfReq       (rfReq),
        .aluReq      (aluReq),
        .respReq     (respReq)
    );

    // Byte sequencer toward the transmitter
    respSender respSender_i (
        .REF_CLK  (REF_CLK),
        .RST      (RST),
        .respReq  (respReq),
        .txBusy   (txBusy),
        .txData   (txData),
        .txValid  (txValid),
        .respDone (respDone)
    );

endmodule

// ==== rtl/respSender.sv ====
`timescale 1ns/1ps

module respSender
    import sysCtrlPkg::*;
(
    input  logic                 REF_CLK,
    input  logic                 RST,
    input  respReqT              respReq,               // From the decoder
    input  logic                 txBusy,                // Transmitter back-pressure
    output logic [DataWidth-1:0] txData,
    output logic                 txValid,               // One byte per high cycle
    output logic                 respDone               // Last byte of response sent
);

    typedef enum logic [1:0]
    {
        Idle,                                           // No response pending
        SendLow,                                        // Low byte waiting for txBusy low
        Gap,                                            // Let the sink raise txBusy
        SendHigh                                        // High byte waiting for txBusy low
    } stateE;

    stateE                  state;
    stateE                  nextState;
    logic [AluOutWidth-1:0] payloadReg;                 // Response held across back-pressure
    logic                   hasHigh;                    // Second byte follows the low byte
    logic                   highNonZero;

    assign highNonZero = |respReq.payload[AluOutWidth-1:DataWidth];

    always_ff @(posedge REF_CLK or negedge RST)
    begin
        if (!RST)
        begin
            state   <= Idle;
            hasHigh <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (state == Idle && respReq.valid)
            begin
                hasHigh <= respReq.isWide && highNonZero;   // Reads stay one byte
            end
        end
    end

    always_ff @(posedge REF_CLK)
    begin
        if (state == Idle && respReq.valid)
        begin
            payloadReg <= respReq.payload;
        end
    end

    always_comb
    begin
        nextState = state;
        txValid   = 1'b0;
        respDone  = 1'b0;
        txData    = payloadReg[DataWidth-1:0];          // Low byte first
        case (state)
            Idle:
            begin
                if (respReq.valid)
                begin
                    nextState = SendLow;
                end
            end
            SendLow:
            begin
                if (!txBusy)
                begin
                    txValid = 1'b1;
                    if (hasHigh)
                    begin
                        nextState = Gap;
                    end
                    else
                    begin
                        respDone  = 1'b1;               // Single-byte response ends here
                        nextState = Idle;
                    end
                end
            end
            Gap:
            begin
                nextState = SendHigh;                   // txBusy not sampled this cycle
            end
            SendHigh:
            begin
                txData = payloadReg[AluOutWidth-1:DataWidth];
                if (!txBusy)
                begin
                    txValid   = 1'b1;
                    respDone  = 1'b1;
                    nextState = Idle;
                end
            end
            default:
            begin
                nextState = Idle;
            end
        endcase
    end

    // No byte offered to a busy transmitter
    assert property (@(posedge REF_CLK) disable iff (!RST) !(txValid && txBusy));

    // Decoder never starts a new response while one is in flight
    assert property (@(posedge REF_CLK) disable iff (!RST) respReq.valid |-> state == Idle);

endmodule

// ==== rtl/cmdDecoder.sv ====
`timescale 1ns/1ps

module cmdDecoder
    import sysCtrlPkg::*;
#(
    parameter logic [AddrWidth-1:0] OperandAAddr = 0,   // Register feeding ALU input A
    parameter logic [AddrWidth-1:0] OperandBAddr = 1    // Register feeding ALU input B
)
(
    input  logic                   REF_CLK,
    input  logic                   RST,
    input  logic [DataWidth-1:0]   rxData,              // Received byte
    input  logic                   rxValid,             // One byte per high cycle
    input  logic [DataWidth-1:0]   rfRdData,
    input  logic                   rfRdValid,
    input  logic [AluOutWidth-1:0] aluOut,
    input  logic                   aluOutValid,
    input  logic                   respDone,            // Last response byte sent
    output rfReqT                  rfReq,
    output aluReqT                 aluReq,
    output respReqT                respReq
);

    typedef enum logic [3:0]
    {
        Idle,                                           // Waiting for an opcode
        WrAddr,                                         // Write command, address byte next
        WrData,                                         // Write command, data byte next
        RdAddr,                                         // Read command, address byte next
        RdWait,                                         // Read issued, waiting for data
        OpA,                                            // Operand A byte next
        OpB,                                            // Operand B byte next
        AluFun,                                         // Function byte next
        AluWait,                                        // ALU busy
        Respond                                         // Sender owns the transmitter
    } stateE;

    stateE                  state;
    stateE                  nextState;
    cmdOpcodeE              rxOpcode;
    logic [AddrWidth-1:0]   addrReg;                    // Captured address byte
    logic                   addrEn;
    logic [AluFunWidth-1:0] funReg;                     // Function held for the ALU wait
    logic                   funEn;
    logic                   resultSeen;                 // Read data or ALU result this cycle
    logic                   respValid;
    logic                   respWide;
    logic [AluOutWidth-1:0] respPayload;

    assign rxOpcode   = cmdOpcodeE'(rxData);           // Unknown values fall to default
    assign resultSeen = (state == RdWait && rfRdValid) || (state == AluWait && aluOutValid);

    always_ff @(posedge REF_CLK or negedge RST)
    begin
        if (!RST)
        begin
            state <= Idle;
        end
        else
        begin
            state <= nextState;
        end
    end

    // Each receive state advances on one byte, wait states on their valid
    always_comb
    begin
        nextState = state;
        case (state)
            Idle:
            begin
                if (rxValid)
                begin
                    case (rxOpcode)
                        RfWrite:   nextState = WrAddr;
                        RfRead:    nextState = RdAddr;
                        AluWithOp: nextState = OpA;
                        AluNoOp:   nextState = AluFun;
                        default:   nextState = Idle;    // Stray byte dropped
                    endcase
                end
            end
            WrAddr:  nextState = rxValid ? WrData : WrAddr;
            WrData:  nextState = rxValid ? Idle : WrData;       // No response for a write
            RdAddr:  nextState = rxValid ? RdWait : RdAddr;
            RdWait:  nextState = rfRdValid ? Respond : RdWait;
            OpA:     nextState = rxValid ? OpB : OpA;
            OpB:     nextState = rxValid ? AluFun : OpB;
            AluFun:  nextState = rxValid ? AluWait : AluFun;
            AluWait: nextState = aluOutValid ? Respond : AluWait;
            Respond: nextState = respDone ? Idle : Respond;    // rx ignored meanwhile
            default: nextState = Idle;
        endcase
    end

    // Request ports, combinational so a write lands in the byte's own cycle
    always_comb
    begin
        rfReq  = '0;
        aluReq = '0;
        addrEn = 1'b0;
        funEn  = 1'b0;
        case (state)
            WrAddr, RdAddr:
            begin
                addrEn = rxValid;                       // Latch address byte
            end
            WrData:
            begin
                rfReq.wrEn   = rxValid;
                rfReq.addr   = addrReg;
                rfReq.wrData = rxData;
            end
            RdWait:
            begin
                rfReq.rdEn = 1'b1;                      // Held with stable address
                rfReq.addr = addrReg;
            end
            OpA:
            begin
                rfReq.wrEn   = rxValid;
                rfReq.addr   = OperandAAddr;
                rfReq.wrData = rxData;
            end
            OpB:
            begin
                rfReq.wrEn   = rxValid;
                rfReq.addr   = OperandBAddr;
                rfReq.wrData = rxData;
            end
            AluFun:
            begin
                aluReq.clkEn = 1'b1;
                aluReq.en    = rxValid;                 // Start with the function byte
                aluReq.fun   = rxData[AluFunWidth-1:0];
                funEn        = rxValid;
            end
            AluWait:
            begin
                aluReq.clkEn = 1'b1;
                aluReq.en    = 1'b1;                    // Held through the result cycle
                aluReq.fun   = funReg;
            end
            default:
            begin
                addrEn = 1'b0;
            end
        endcase
    end

    always_ff @(posedge REF_CLK)
    begin
        if (addrEn)
        begin
            addrReg <= rxData[AddrWidth-1:0];           // Upper address bits unused
        end
        if (funEn)
        begin
            funReg <= rxData[AluFunWidth-1:0];
        end
    end

    always_ff @(posedge REF_CLK or negedge RST)
    begin
        if (!RST)
        begin
            respValid <= 1'b0;
        end
        else
        begin
            respValid <= resultSeen;                    // Pulse one cycle after result
        end
    end

    always_ff @(posedge REF_CLK)
    begin
        if (resultSeen)
        begin
            respWide    <= (state == AluWait);
            respPayload <= (state == AluWait) ? aluOut
                         : {{(AluOutWidth - DataWidth){1'b0}}, rfRdData};
        end
    end

    assign respReq = '{valid: respValid, isWide: respWide, payload: respPayload};

    // Register file port never reads and writes in one cycle
    assert property (@(posedge REF_CLK) disable iff (!RST) !(rfReq.wrEn && rfReq.rdEn));

    // Sender only finishes a response that this decoder handed over
    assert property (@(posedge REF_CLK) disable iff (!RST) respDone |-> state == Respond);

endmodule

// ==== common/sysCtrlPkg.sv ====
package sysCtrlPkg;

    // Fixed widths shared by the controller and its request structs
    parameter int DataWidth   = 8;                  // UART and register file byte
    parameter int AddrWidth   = 4;                  // Register file has 16 entries
    parameter int AluFunWidth = 4;                  // ALU function select
    parameter int AluOutWidth = 2 * DataWidth;      // Full ALU result, two bytes

    // Command bytes as they arrive from the UART receiver
    typedef enum logic [7:0]
    {
        RfWrite   = 8'hAA,                          // Address byte, then data byte
        RfRead    = 8'hBB,                          // Address byte only
        AluWithOp = 8'hCC,                          // Operand A, operand B, function
        AluNoOp   = 8'hDD                           // Function byte only
    } cmdOpcodeE;

    // Register file request port
    typedef struct packed
    {
        logic                 wrEn;                 // One write per cycle while high
        logic                 rdEn;                 // Held until read data returns
        logic [AddrWidth-1:0] addr;                 // Shared read/write address
        logic [DataWidth-1:0] wrData;               // Write payload
    } rfReqT;

    // ALU request port
    typedef struct packed
    {
        logic                   en;                 // Start, held until result returns
        logic                   clkEn;              // ALU clock gate enable
        logic [AluFunWidth-1:0] fun;                // Operation select
    } aluReqT;

    // Decoder to sender, one response per command
    typedef struct packed
    {
        logic                   valid;              // Single-cycle pulse
        logic                   isWide;             // Payload is an ALU result
        logic [AluOutWidth-1:0] payload;            // Read byte zero-extended, or ALU result
    } respReqT;

endpackage
